//--- Makefile
VERILATOR ?= verilator
TOP       ?= dataCacheTb
FILELIST  ?= dataCache.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJDIR)

//--- dataCache.f
src/cachePkg.sv
src/busPkg.sv
src/cacheTags.sv
src/cacheData.sv
src/cacheFsm.sv
src/dataCache.sv
dv/cacheChecker.sv
dv/dataCacheTb.sv

//--- dv/cacheChecker.sv
`timescale 1ns/100ps
`default_nettype none

module cacheChecker import cachePkg::*, busPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  cpuReqT              req,
  input  logic                flush,
  input  busReqT              busReq,
  input  busRspT              busRsp,
  input  logic                stall,
  input  logic [wordBits-1:0] rdata,
  input  logic                hitStrobe,
  input  logic                missStrobe,
  input  logic                rowDone,
  input  logic                lastRow,
  input  logic [3:0]          testNum,
  input  logic [3:0]          expFetches,
  input  logic [3:0]          expWriteBacks,
  input  logic                allDone,
  output int                  errors
);

  // memory as the core expects it and as the bus has left it
  logic [wordBits-1:0] shadow  [1 << lineAdrBits];
  logic [wordBits-1:0] image   [1 << lineAdrBits];
  logic                written [1 << lineAdrBits];

  // bus traffic of the current row
  int fetches = 0;
  int writeBacks = 0;
  // strobes and completed accesses of the current row
  int hits = 0;
  int misses = 0;
  int accesses = 0;
  int checks = 0;
  int errCount = 0;
  int testErrors = 0;
  int tests = 0;

  assign errors = errCount;

  task automatic expectValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      errCount++;
      testErrors++;
    end
  endtask

  always @(posedge clk) begin
    int base;
    int wordAdr;
    base    = int'(busReq.lineAdr);
    // byte address over four
    wordAdr = int'(req.adr[15:2]);
    if (reset) begin
      // untouched memory holds word address xor A5A5
      for (int i = 0; i < $size(shadow); i++) begin
        shadow[i]  = {16'h0, i[15:0] ^ 16'hA5A5};
        image[i]   = shadow[i];
        written[i] = 1'b0;
      end
    end else begin
      // idle core and no flush means a quiet cache
      if (req.op == idle && !flush) begin
        expectValue("stall", 32'(stall), 32'd0);
        expectValue("busReq.fetch", 32'(busReq.fetch), 32'd0);
        expectValue("busReq.writeBack", 32'(busReq.writeBack), 32'd0);
      end
      if (hitStrobe) begin
        hits++;
      end
      if (missStrobe) begin
        misses++;
      end
      if (!stall && !flush && req.op != idle) begin
        accesses++;
      end
      // fetch goes to the first word of the requested line
      if (busRsp.ack && busReq.fetch) begin
        fetches++;
        expectValue("busReq.lineAdr", 32'(busReq.lineAdr), 32'(wordAdr & ~3));
      end
      // written-back line must carry the core's latest data
      if (busRsp.ack && busReq.writeBack) begin
        writeBacks++;
        for (int w = 0; w < wordsPerLine; w++) begin
          expectValue("busReq.wline", busReq.wline[w*32 +: 32], shadow[base + w]);
          image[base + w] = busReq.wline[w*32 +: 32];
        end
      end
      if (!stall && !flush && req.op == read) begin
        expectValue("rdata", rdata, shadow[wordAdr]);
      end
      if (!stall && !flush && req.op == write) begin
        shadow[wordAdr]  = req.wdata;
        written[wordAdr] = 1'b1;
      end
      // after a flush memory matches every written word
      if (!stall && flush) begin
        for (int i = 0; i < $size(shadow); i++) begin
          if (written[i]) begin
            expectValue("memory word", image[i], shadow[i]);
          end
        end
      end
      if (rowDone) begin
        expectValue("fetch count", fetches, 32'(expFetches));
        expectValue("write-back count", writeBacks, 32'(expWriteBacks));
        // each miss fetches once, each access gives one strobe
        expectValue("missStrobe count", misses, 32'(expFetches));
        expectValue("hitStrobe plus missStrobe count", hits + misses, accesses);
        fetches    = 0;
        writeBacks = 0;
        hits       = 0;
        misses     = 0;
        accesses   = 0;
        if (lastRow) begin
          $display("test %0d finished with %0d errors", testNum, testErrors);
          tests++;
          testErrors = 0;
        end
      end
      if (allDone) begin
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errCount);
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/dataCacheTb.sv
`timescale 1ns/100ps
`default_nettype none

module dataCacheTb import cachePkg::*, busPkg::*; ();

  // one table row holds a single core access or a flush
  typedef struct packed {
    logic [3:0]  testNum;
    logic        flush;
    cpuOpT       op;
    logic [15:0] adr;
    logic [31:0] wdata;
    logic [3:0]  expFetches;
    logic [3:0]  expWriteBacks;
  } stimRowT;

  logic clk;
  logic reset;
  cpuReqT req;
  logic flush;
  busReqT busReq;
  busRspT busRsp = '0;
  logic stall;
  logic [wordBits-1:0] rdata;
  logic hitStrobe;
  logic missStrobe;

  // row results toward the checker
  logic rowDone, lastRow, allDone, hung;
  logic [3:0] testNum, expFetches, expWriteBacks;
  int errors;
  int stallLimit = 400;
  stimRowT stimTable [$];

  dataCache uut (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .flush      (flush),
    .busRsp     (busRsp),
    .busReq     (busReq),
    .stall      (stall),
    .rdata      (rdata),
    .hitStrobe  (hitStrobe),
    .missStrobe (missStrobe)
  );

  cacheChecker scoreboard (
    .clk           (clk),
    .reset         (reset),
    .req           (req),
    .flush         (flush),
    .busReq        (busReq),
    .busRsp        (busRsp),
    .stall         (stall),
    .rdata         (rdata),
    .hitStrobe     (hitStrobe),
    .missStrobe    (missStrobe),
    .rowDone       (rowDone),
    .lastRow       (lastRow),
    .testNum       (testNum),
    .expFetches    (expFetches),
    .expWriteBacks (expWriteBacks),
    .allDone       (allDone),
    .errors        (errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // memory model with random ack delay
  //////////////////////////////////////////////////

  logic [31:0] mem [1 << lineAdrBits];
  logic [2:0]  ackWait;
  logic [31:0] rngState;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  always @(posedge clk) begin
    int base;
    base = int'(busReq.lineAdr);
    busRsp.ack <= 1'b0;
    if (reset) begin
      for (int i = 0; i < $size(mem); i++) begin
        mem[i] <= {16'h0, i[15:0] ^ 16'hA5A5};
      end
      ackWait  <= 3'd0;
      rngState <= 32'd40308;
    end else if ((busReq.fetch || busReq.writeBack) && !busRsp.ack) begin
      if (ackWait != 3'd0) begin
        ackWait <= ackWait - 3'd1;
      end else begin
        busRsp.ack <= 1'b1;
        for (int w = 0; w < wordsPerLine; w++) begin
          busRsp.rline[w*32 +: 32] <= mem[base + w];
          if (busReq.writeBack) begin
            mem[base + w] <= busReq.wline[w*32 +: 32];
          end
        end
        // delay before the next ack is 0 to 5 cycles
        ackWait  <= 3'((lcgNext(rngState) >> 16) % 32'd6);
        rngState <= lcgNext(rngState);
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////

  task automatic addRow(input int test, input logic fl, input cpuOpT op, input logic [15:0] adr,
                        input logic [31:0] wd, input int nf, input int nw);
    stimRowT r;
    r.testNum       = 4'(test);
    r.flush         = fl;
    r.op            = op;
    r.adr           = adr;
    r.wdata         = wd;
    r.expFetches    = 4'(nf);
    r.expWriteBacks = 4'(nw);
    stimTable.push_back(r);
  endtask

  task automatic buildTable();
    addRow(1, 1'b0, idle,  16'h0000, 32'h0, 0, 0);
    // miss then hits in set 3
    addRow(2, 1'b0, read,  16'h1234, 32'h0, 1, 0);
    addRow(2, 1'b0, read,  16'h1234, 32'h0, 0, 0);
    addRow(2, 1'b0, read,  16'h123C, 32'h0, 0, 0);
    addRow(3, 1'b0, write, 16'h2040, 32'hDEADBEEF, 1, 0);
    addRow(3, 1'b0, read,  16'h2040, 32'h0, 0, 0);
    // three tags in set 5 where the dirty first line is LRU at the third
    addRow(4, 1'b0, write, 16'h3050, 32'h11111111, 1, 0);
    addRow(4, 1'b0, read,  16'h4054, 32'h0, 1, 0);
    addRow(4, 1'b0, read,  16'h5058, 32'h0, 1, 1);
    addRow(4, 1'b0, read,  16'h3050, 32'h0, 1, 0);
    // five dirty lines then two flushes
    addRow(5, 1'b0, write, 16'h3054, 32'h22222222, 0, 0);
    addRow(5, 1'b0, write, 16'h6070, 32'h33333333, 1, 0);
    addRow(5, 1'b0, write, 16'h7070, 32'h44444444, 1, 0);
    addRow(5, 1'b0, write, 16'h1238, 32'h55555555, 0, 0);
    addRow(5, 1'b1, idle,  16'h0000, 32'h0, 0, 5);
    addRow(5, 1'b1, idle,  16'h0000, 32'h0, 0, 0);
    addRow(5, 1'b0, read,  16'h3054, 32'h0, 0, 0);
    // two dirty evictions in set 9 with data read back from memory
    addRow(6, 1'b0, write, 16'h8090, 32'h66666666, 1, 0);
    addRow(6, 1'b0, write, 16'h9094, 32'h77777777, 1, 0);
    addRow(6, 1'b0, read,  16'hA098, 32'h0, 1, 1);
    addRow(6, 1'b0, read,  16'h8090, 32'h0, 1, 1);
    addRow(6, 1'b0, read,  16'h9094, 32'h0, 1, 0);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int cyc;
    logic waiting;
    stimRowT row;
    req = '0;
    flush = 1'b0;
    reset = 1'b1;
    rowDone = 1'b0;
    lastRow = 1'b0;
    allDone = 1'b0;
    hung = 1'b0;
    testNum = '0;
    expFetches = '0;
    expWriteBacks = '0;
    buildTable();
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < stimTable.size() && !hung; i++) begin
      row = stimTable[i];
      @(posedge clk);
      rowDone   <= 1'b0;
      req.op    <= row.op;
      req.adr   <= row.adr;
      req.wdata <= row.wdata;
      flush     <= row.flush;
      // request is held until stall is low at an edge
      waiting = 1'b1;
      cyc = 0;
      while (waiting) begin
        @(posedge clk);
        cyc++;
        if (!stall) begin
          waiting = 1'b0;
        end else if (cyc >= stallLimit) begin
          $display("stall stayed high for %0d cycles in test %0d, the cache hangs",
                   cyc, row.testNum);
          hung = 1'b1;
          waiting = 1'b0;
        end
      end
      req           <= '0;
      flush         <= 1'b0;
      rowDone       <= !hung;
      lastRow       <= (i == stimTable.size() - 1) || (stimTable[i + 1].testNum != row.testNum);
      testNum       <= row.testNum;
      expFetches    <= row.expFetches;
      expWriteBacks <= row.expWriteBacks;
    end
    @(posedge clk);
    rowDone <= 1'b0;
    allDone <= 1'b1;
    @(posedge clk);
    allDone <= 1'b0;
    @(posedge clk);
    if (hung || errors != 0) begin
      $display("TEST RESULT: FAIL");
    end else begin
      $display("TEST RESULT: PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/busPkg.sv
`default_nettype none

package busPkg;

  // line address is the word address of the line's first word
  localparam int lineAdrBits = 14;
  localparam int lineBits    = 128;

  // fetch and writeBack are levels held until ack
  typedef struct packed {
    logic                   fetch;
    logic                   writeBack;
    logic [lineAdrBits-1:0] lineAdr;
    logic [lineBits-1:0]    wline;
  } busReqT;

  // ack is a single-cycle pulse, rline valid with it on a fetch
  typedef struct packed {
    logic                ack;
    logic [lineBits-1:0] rline;
  } busRspT;

endpackage

`default_nettype wire

//--- src/cacheData.sv
`timescale 1ns/100ps
`default_nettype none

module cacheData import cachePkg::*; (
  input  logic                   clk,
  input  arrayCtrlT              ctrl,
  input  logic [wordIdxBits-1:0] wordIdx,
  input  logic [wordBits-1:0]    wdata,
  input  cacheLineT              fillLine,
  output cacheLineT [numWays-1:0] lines
);

  // line storage for all sets and ways
  cacheLineT lineMem [numSets][numWays];

  // fill replaces the whole line
  // a word write touches one word of the target way only
  always_ff @(posedge clk) begin
    if (ctrl.fill) begin
      lineMem[ctrl.setIdx][ctrl.way] <= fillLine;
    end else if (ctrl.wordWe) begin
      lineMem[ctrl.setIdx][ctrl.way][wordIdx] <= wdata;
    end
  end

  // both ways presented, controller picks hit or victim
  always_comb begin
    for (int w = 0; w < numWays; w++) begin
      lines[w] = lineMem[ctrl.setIdx][w];
    end
  end

endmodule

`default_nettype wire

//--- src/cacheFsm.sv
`timescale 1ns/100ps
`default_nettype none

module cacheFsm import cachePkg::*, busPkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  cpuReqT                  req,
  input  logic                    flush,
  input  tagLookupT               lookup,
  input  cacheLineT [numWays-1:0] lines,
  input  busRspT                  busRsp,
  output arrayCtrlT               ctrl,
  output cacheLineT               fillLine,
  output busReqT                  busReq,
  output logic                    stall,
  output logic [wordBits-1:0]     rdata,
  output logic                    hitStrobe,
  output logic                    missStrobe
);

  typedef enum logic [2:0] {
    stReady,
    stFetch,
    stEvict,
    stFill,
    stFlushCheck,
    stFlushWriteBack,
    stFlushClearDirty,
    stFlushNext
  } stateT;

  stateT state, nextState;

  logic               access, doFlush, hitNow, missNow;
  logic               flushing, flushLast, flushDirty, victimDirty;
  logic               victimWay, targetWay;
  logic               flushWay, flushDone, refilled;
  logic [setBits-1:0] flushSet, lookupSet;
  tagEntryT           targetEntry;
  // refill line parked here until the victim is gone
  cacheLineT          busBuf;

  //////////////////////////////////////////////////
  // request decode
  //////////////////////////////////////////////////

  assign access = (req.op == read) || (req.op == write);
  // a served flush stays done until the core takes stall low
  assign doFlush = flush && !flushDone;
  assign hitNow  = (state == stReady) && !doFlush && access && lookup.hit;
  assign missNow = (state == stReady) && !doFlush && access && !lookup.hit;
  assign flushing = (state == stFlushCheck) || (state == stFlushWriteBack) ||
                    (state == stFlushClearDirty) || (state == stFlushNext);

  // flush walks the sets, otherwise the request picks the set
  assign lookupSet = flushing ? flushSet : req.adr.setIdx;

  always_comb begin
    if (flushing) begin
      targetWay = flushWay;
    end else if (state == stReady) begin
      targetWay = lookup.hitWay;
    end else begin
      targetWay = victimWay;
    end
  end

  assign targetEntry = lookup.ways[targetWay];
  assign flushLast   = (flushSet == setBits'(numSets - 1)) && (flushWay == 1'(numWays - 1));
  // dirty implies valid, no separate check
  assign flushDirty  = lookup.ways[flushWay].dirty;
  assign victimDirty = lookup.ways[lookup.replWay].dirty;

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stReady;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      stReady: begin
        // flush goes ahead of a request held with it
        if (doFlush) begin
          nextState = stFlushCheck;
        end else if (missNow) begin
          nextState = stFetch;
        end
      end
      // refill first, victim leaves afterwards
      stFetch: begin
        if (busRsp.ack) begin
          nextState = victimDirty ? stEvict : stFill;
        end
      end
      stEvict: begin
        if (busRsp.ack) begin
          nextState = stFill;
        end
      end
      stFill:
        nextState = stReady;
      stFlushCheck: begin
        if (flushDirty) begin
          nextState = stFlushWriteBack;
        end else if (flushLast) begin
          nextState = stReady;
        end else begin
          nextState = stFlushNext;
        end
      end
      stFlushWriteBack: begin
        if (busRsp.ack) begin
          nextState = stFlushClearDirty;
        end
      end
      stFlushClearDirty:
        nextState = flushLast ? stReady : stFlushNext;
      stFlushNext:
        nextState = stFlushCheck;
      default:
        nextState = stReady;
    endcase
  end

  //////////////////////////////////////////////////
  // victim, flush counters, bus buffer
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state == stFetch && busRsp.ack) begin
      busBuf <= busRsp.rline;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      victimWay <= 1'b0;
      flushSet  <= '0;
      flushWay  <= 1'b0;
      flushDone <= 1'b0;
      refilled  <= 1'b0;
    end else begin
      // replacement way is stable during fetch, take it with the line
      if (state == stFetch && busRsp.ack) begin
        victimWay <= lookup.replWay;
      end
      // counters sit at set 0, way 0 while idle
      if (state == stReady) begin
        flushSet <= '0;
        flushWay <= 1'b0;
      end else if (state == stFlushNext) begin
        flushWay <= ~flushWay;
        if (flushWay) begin
          flushSet <= flushSet + 1'b1;
        end
      end
      if (state == stReady && !stall) begin
        flushDone <= 1'b0;
      end else if (flushing && nextState == stReady) begin
        flushDone <= 1'b1;
      end
      // marks the replayed hit right after a fill
      refilled <= (state == stFill);
    end
  end

  //////////////////////////////////////////////////
  // array commands and outputs
  //////////////////////////////////////////////////

  always_comb begin
    ctrl        = '0;
    ctrl.setIdx = lookupSet;
    ctrl.way    = targetWay;
    case (state)
      stReady: begin
        if (hitNow) begin
          ctrl.wordWe    = (req.op == write);
          ctrl.setDirty  = (req.op == write);
          ctrl.lruUpdate = 1'b1;
        end
      end
      // fresh line from memory is clean
      stFill: begin
        ctrl.fill       = 1'b1;
        ctrl.clearDirty = 1'b1;
      end
      stFlushClearDirty:
        ctrl.clearDirty = 1'b1;
      default: begin
      end
    endcase
  end

  assign fillLine = busBuf;

  always_comb begin
    busReq.fetch     = (state == stFetch);
    busReq.writeBack = (state == stEvict) || (state == stFlushWriteBack);
    // write-back goes to the stored tag, fetch to the request's line
    if (busReq.fetch) begin
      busReq.lineAdr = {req.adr.tag, req.adr.setIdx, {wordIdxBits{1'b0}}};
    end else begin
      busReq.lineAdr = {targetEntry.tag, lookupSet, {wordIdxBits{1'b0}}};
    end
    busReq.wline = lines[targetWay];
  end

  // stall held through every state but a serviceable ready
  assign stall      = (state != stReady) || doFlush || (access && !lookup.hit);
  assign rdata      = lines[lookup.hitWay][req.adr.wordIdx];
  // replayed hit after a miss is not counted again
  assign hitStrobe  = hitNow && !refilled;
  assign missStrobe = missNow;

endmodule

`default_nettype wire

//--- src/cachePkg.sv
`default_nettype none

package cachePkg;

  // cache geometry
  localparam int numSets      = 16;
  localparam int numWays      = 2;
  localparam int wordsPerLine = 4;
  localparam int tagBits      = 8;
  localparam int wordBits     = 32;
  localparam int setBits      = $clog2(numSets);
  localparam int wordIdxBits  = $clog2(wordsPerLine);

  // 16-bit byte address split into its cache fields
  typedef struct packed {
    logic [tagBits-1:0]     tag;
    logic [setBits-1:0]     setIdx;
    logic [wordIdxBits-1:0] wordIdx;
    logic [1:0]             byteOff;
  } cacheAdrT;

  typedef enum logic [1:0] {idle, read, write} cpuOpT;

  // one core request, held until stall drops
  typedef struct packed {
    cpuOpT               op;
    cacheAdrT            adr;
    logic [wordBits-1:0] wdata;
  } cpuReqT;

  typedef logic [wordsPerLine-1:0][wordBits-1:0] cacheLineT;

  // per-way state kept in the tag array
  typedef struct packed {
    logic [tagBits-1:0] tag;
    logic               valid;
    logic               dirty;
  } tagEntryT;

  // tag array result for the current lookup set
  typedef struct packed {
    tagEntryT [numWays-1:0] ways;
    logic                   hit;
    logic                   hitWay;
    logic                   replWay;
  } tagLookupT;

  // controller commands, shared by both arrays
  typedef struct packed {
    logic [setBits-1:0] setIdx;
    logic               way;
    logic               wordWe;
    logic               fill;
    logic               setDirty;
    logic               clearDirty;
    logic               lruUpdate;
  } arrayCtrlT;

endpackage

`default_nettype wire

//--- src/cacheTags.sv
`timescale 1ns/100ps
`default_nettype none

module cacheTags import cachePkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  arrayCtrlT          ctrl,
  input  logic [tagBits-1:0] reqTag,
  output tagLookupT          lookup
);

  // tag storage per set and way
  logic [tagBits-1:0] tagMem [numSets][numWays];

  // state bits, cleared on reset
  logic [numSets-1:0][numWays-1:0] validBits;
  logic [numSets-1:0][numWays-1:0] dirtyBits;
  // one bit per set, names the least recently used way
  logic [numSets-1:0]              lruBits;

  // per-way tag match
  logic [numWays-1:0] wayHit;

  //////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////

  always_comb begin
    for (int w = 0; w < numWays; w++) begin
      lookup.ways[w].tag   = tagMem[ctrl.setIdx][w];
      lookup.ways[w].valid = validBits[ctrl.setIdx][w];
      lookup.ways[w].dirty = dirtyBits[ctrl.setIdx][w];
      // only a valid way can match
      wayHit[w] = validBits[ctrl.setIdx][w] && (tagMem[ctrl.setIdx][w] == reqTag);
    end
    lookup.hit    = |wayHit;
    lookup.hitWay = wayHit[1];
    // fill empty ways first, then fall back to LRU
    if (!validBits[ctrl.setIdx][0]) begin
      lookup.replWay = 1'b0;
    end else if (!validBits[ctrl.setIdx][1]) begin
      lookup.replWay = 1'b1;
    end else begin
      lookup.replWay = lruBits[ctrl.setIdx];
    end
  end

  //////////////////////////////////////////////////
  // updates
  //////////////////////////////////////////////////

  // new tag written with the line fill
  always_ff @(posedge clk) begin
    if (ctrl.fill) begin
      tagMem[ctrl.setIdx][ctrl.way] <= reqTag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
      lruBits   <= '0;
    end else begin
      if (ctrl.fill) begin
        validBits[ctrl.setIdx][ctrl.way] <= 1'b1;
      end
      // set wins, the controller never asks for both
      if (ctrl.setDirty) begin
        dirtyBits[ctrl.setIdx][ctrl.way] <= 1'b1;
      end else if (ctrl.clearDirty) begin
        dirtyBits[ctrl.setIdx][ctrl.way] <= 1'b0;
      end
      // the other way becomes the LRU one
      if (ctrl.lruUpdate) begin
        lruBits[ctrl.setIdx] <= ~ctrl.way;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/dataCache.sv
`timescale 1ns/100ps
`default_nettype none

module dataCache import cachePkg::*, busPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  cpuReqT              req,
  input  logic                flush,
  input  busRspT              busRsp,
  output busReqT              busReq,
  output logic                stall,
  output logic [wordBits-1:0] rdata,
  output logic                hitStrobe,
  output logic                missStrobe
);

  // controller to arrays
  arrayCtrlT               ctrl;
  cacheLineT               fillLine;
  // arrays back to controller
  tagLookupT               lookup;
  cacheLineT [numWays-1:0] lines;

  // tag, valid, dirty and LRU state
  cacheTags tags (
    .clk    (clk),
    .reset  (reset),
    .ctrl   (ctrl),
    .reqTag (req.adr.tag),
    .lookup (lookup)
  );

  // line data of both ways
  cacheData data (
    .clk      (clk),
    .ctrl     (ctrl),
    .wordIdx  (req.adr.wordIdx),
    .wdata    (req.wdata),
    .fillLine (fillLine),
    .lines    (lines)
  );

  cacheFsm fsm (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .flush      (flush),
    .lookup     (lookup),
    .lines      (lines),
    .busRsp     (busRsp),
    .ctrl       (ctrl),
    .fillLine   (fillLine),
    .busReq     (busReq),
    .stall      (stall),
    .rdata      (rdata),
    .hitStrobe  (hitStrobe),
    .missStrobe (missStrobe)
  );

endmodule

`default_nettype wire
